/* spmm_top.f */
+incdir+include
source/spmm_pkg.sv
source/burst_counter.sv
source/row_scheduler.sv
source/segment_reducer.sv
source/column_pe.sv
source/rhs_buffer.sv
source/out_buffer.sv
source/spmm_top.sv
test/spmm_tb.sv

/* Bender.yml */
package:
  name: spmm

sources:
  - include_dirs:
      - include
    files:
      - source/spmm_pkg.sv
      - source/burst_counter.sv
      - source/row_scheduler.sv
      - source/segment_reducer.sv
      - source/column_pe.sv
      - source/rhs_buffer.sv
      - source/out_buffer.sv
      - source/spmm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/spmm_tb.sv

/* test/spmm_tb.sv */
`timescale 1ns/10ps
`include "spmm_params.svh"

module spmm_tb;
    import spmm_pkg::*;

    localparam int N = `SPMM_N;
    localparam int W = `SPMM_W;
    localparam int LG = `SPMM_LG_N;
    localparam int ROWS = `SPMM_BEAT_ROWS;
    localparam int BEATS = `SPMM_BEATS;
    localparam int LAT = `SPMM_PE_LAT;
    localparam int JOBS = 6;
    localparam int LIMIT = 4 * (JOBS * (N + BEATS + LAT + 20));

    logic  clock;
    logic  reset;
    logic  lhs_ready;
    logic  lhs_start;
    flat_t lhs_row_end [N];
    lane_t lhs_col [N];
    data_t lhs_data [N];
    logic  rhs_ready;
    logic  rhs_start;
    data_t rhs_data [ROWS][N];
    logic  out_ready;
    logic  out_start;
    data_t out_data [ROWS][N];

    // two job slots, enough for back-to-back traffic
    data_t b_mat [2][N][N];
    lane_t a_col [2][N*N];
    data_t a_val [2][N*N];
    flat_t r_end [2][N];
    data_t exp_c [2][N][N];
    int    row_len [N];

    logic [15:0] lfsr = 16'd56330;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int test_mark = 0;
    int tests_run = 0;
    int tests_failed = 0;

    spmm_top spmm_top_inst (
        .clock(clock),
        .reset(reset),
        .lhs_ready(lhs_ready),
        .lhs_start(lhs_start),
        .lhs_row_end(lhs_row_end),
        .lhs_col(lhs_col),
        .lhs_data(lhs_data),
        .rhs_ready(rhs_ready),
        .rhs_start(rhs_start),
        .rhs_data(rhs_data),
        .out_ready(out_ready),
        .out_start(out_start),
        .out_data(out_data)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // Galois LFSR, taps 16,14,13,11, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_output_zero();
        for (int i = 0; i < ROWS; i++) begin
            for (int j = 0; j < N; j++) begin
                check_value($sformatf("out_data[%0d][%0d]", i, j), 0, out_data[i][j]);
            end
        end
    endtask

    task automatic begin_test();
        test_mark = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_mark) begin
            tests_failed++;
        end
        $display("test %0d, %s: %0d errors", tests_run, name, errors - test_mark);
    endtask

    // every row in first..N-1 gets at least one nonzero
    task automatic spread_lengths(input int first, input int total);
        int pick;
        for (int r = first; r < N; r++) begin
            row_len[r] = 1;
        end
        for (int k = 0; k < total - (N - first); k++) begin
            pick = first + int'(rand_bits(LG)) % (N - first);
            row_len[pick]++;
        end
    endtask

    task automatic long_row_lengths();
        row_len[0] = 3;
        row_len[1] = N + 5;
        spread_lengths(2, N * N - N - 8);
    endtask

    task automatic empty_row_lengths();
        row_len[0] = N + 2;
        row_len[1] = 0;
        row_len[2] = 0;
        spread_lengths(3, N * N - N - 2);
        if (N >= 8) begin
            row_len[6] += row_len[5];
            row_len[5] = 0;
        end
    endtask

    // random B and A, row ends from row_len, and the expected C
    task automatic build_job(input int slot);
        int f;
        f = 0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                b_mat[slot][r][c] = data_t'(rand_bits(W));
            end
        end
        for (int k = 0; k < N * N; k++) begin
            a_col[slot][k] = lane_t'(rand_bits(LG));
            a_val[slot][k] = data_t'(rand_bits(W));
        end
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                exp_c[slot][r][c] = '0;
            end
            for (int e = 0; e < row_len[r]; e++) begin
                for (int c = 0; c < N; c++) begin
                    exp_c[slot][r][c] = data_t'(exp_c[slot][r][c]
                        + a_val[slot][f] * b_mat[slot][a_col[slot][f]][c]);
                end
                f++;
            end
            // an empty row repeats the previous end
            r_end[slot][r] = flat_t'(f - 1);
        end
    endtask

    task automatic send_rhs(input int slot);
        @(posedge clock);
        while (!rhs_ready) @(posedge clock);
        for (int k = 0; k < BEATS; k++) begin
            rhs_start <= (k == 0);
            for (int i = 0; i < ROWS; i++) begin
                for (int j = 0; j < N; j++) begin
                    rhs_data[i][j] <= b_mat[slot][k * ROWS + i][j];
                end
            end
            @(posedge clock);
        end
        rhs_start <= 1'b0;
    endtask

    task automatic send_lhs(input int slot);
        @(posedge clock);
        while (!lhs_ready) @(posedge clock);
        for (int j = 0; j < N; j++) begin
            lhs_row_end[j] <= r_end[slot][j];
        end
        for (int k = 0; k < N; k++) begin
            lhs_start <= (k == 0);
            for (int j = 0; j < N; j++) begin
                lhs_col[j] <= a_col[slot][k * N + j];
                lhs_data[j] <= a_val[slot][k * N + j];
            end
            @(posedge clock);
        end
        lhs_start <= 1'b0;
        for (int j = 0; j < N; j++) begin
            lhs_col[j] <= '0;
            lhs_data[j] <= '0;
        end
    endtask

    // waits delay cycles with out_ready high before reading
    task automatic read_result(input int slot, input int delay);
        @(posedge clock);
        while (!out_ready) @(posedge clock);
        for (int d = 0; d < delay; d++) begin
            @(negedge clock);
            check_value("out_ready", 1, out_ready);
            check_output_zero();
            @(posedge clock);
        end
        out_start <= 1'b1;
        for (int k = 0; k < BEATS; k++) begin
            @(negedge clock);
            for (int i = 0; i < ROWS; i++) begin
                for (int j = 0; j < N; j++) begin
                    check_value($sformatf("out_data[%0d][%0d] (C row %0d)", i, j, k * ROWS + i),
                        exp_c[slot][k * ROWS + i][j], out_data[i][j]);
                end
            end
            @(posedge clock);
            out_start <= 1'b0;
        end
        @(negedge clock);
        check_output_zero();
    endtask

    initial begin
        int waited;
        reset = 1'b1;
        lhs_start = 1'b0;
        rhs_start = 1'b0;
        out_start = 1'b0;
        for (int j = 0; j < N; j++) begin
            lhs_row_end[j] = '0;
            lhs_col[j] = '0;
            lhs_data[j] = '0;
        end
        for (int i = 0; i < ROWS; i++) begin
            for (int j = 0; j < N; j++) begin
                rhs_data[i][j] = '0;
            end
        end

        begin_test();
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("rhs_ready", 0, rhs_ready);
        check_value("lhs_ready", 0, lhs_ready);
        check_value("out_ready", 0, out_ready);
        check_output_zero();
        waited = 0;
        while (!rhs_ready && waited < 4) begin
            @(negedge clock);
            waited++;
        end
        check_value("rhs_ready", 1, rhs_ready);
        check_value("lhs_ready", 0, lhs_ready);
        check_value("out_ready", 0, out_ready);
        end_test("reset state and idle readies");

        begin_test();
        spread_lengths(0, N * N);
        build_job(0);
        send_rhs(0);
        send_lhs(0);
        read_result(0, 0);
        end_test("single random job");

        begin_test();
        long_row_lengths();
        build_job(0);
        send_rhs(0);
        send_lhs(0);
        read_result(0, 0);
        end_test("rows across beat boundaries");

        begin_test();
        empty_row_lengths();
        build_job(0);
        send_rhs(0);
        send_lhs(0);
        read_result(0, 0);
        end_test("empty rows");

        // second B goes in during the first A burst
        begin_test();
        spread_lengths(0, N * N);
        build_job(0);
        spread_lengths(0, N * N);
        build_job(1);
        send_rhs(0);
        fork
            send_lhs(0);
            begin
                repeat (2) @(posedge clock);
                send_rhs(1);
            end
        join
        send_lhs(1);
        read_result(0, 0);
        read_result(1, 0);
        end_test("back-to-back jobs");

        begin_test();
        spread_lengths(0, N * N);
        build_job(0);
        send_rhs(0);
        send_lhs(0);
        read_result(0, 10);
        end_test("delayed read");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
            tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* source/spmm_top.sv */
`timescale 1ns/10ps
`include "spmm_params.svh"

module spmm_top (
    input  logic            clock,
    input  logic            reset,
    output logic            lhs_ready,
    input  logic            lhs_start,
    input  spmm_pkg::flat_t lhs_row_end [`SPMM_N],
    input  spmm_pkg::lane_t lhs_col [`SPMM_N],
    input  spmm_pkg::data_t lhs_data [`SPMM_N],
    output logic            rhs_ready,
    input  logic            rhs_start,
    input  spmm_pkg::data_t rhs_data [`SPMM_BEAT_ROWS][`SPMM_N],
    output logic            out_ready,
    input  logic            out_start,
    output spmm_pkg::data_t out_data [`SPMM_BEAT_ROWS][`SPMM_N]
);
    import spmm_pkg::*;

    localparam int N = `SPMM_N;
    localparam int LAT = `SPMM_PE_LAT;
    // long enough to mark both the last A beat and the PE output
    localparam int DLY = (LAT > N - 1) ? LAT : N - 1;

    logic [DLY-1:0] start_pipe;
    logic           lhs_busy;
    logic           release_bank;
    logic           collect_start;
    logic           active_ready;
    logic           split [N];
    lane_t          out_idx [N];
    logic           out_valid [N];
    data_t          rhs_cols [N][N];
    data_t          pe_out [N][N];
    logic           pe_valid [N][N];

    always_ff @(posedge clock) begin
        if (reset) begin
            start_pipe <= '0;
            lhs_ready <= 1'b0;
        end else begin
            start_pipe <= {start_pipe[DLY-2:0], lhs_start};
            lhs_ready <= active_ready && !lhs_start && !lhs_busy;
        end
    end

    // A burst still on the lanes
    assign lhs_busy = |start_pipe[N-2:0];
    assign release_bank = start_pipe[N-2];
    assign collect_start = start_pipe[LAT-1];

    row_scheduler row_scheduler_inst (
        .clock(clock),
        .reset(reset),
        .lhs_start(lhs_start),
        .row_end(lhs_row_end),
        .split(split),
        .out_idx(out_idx),
        .out_valid(out_valid)
    );

    rhs_buffer rhs_buffer_inst (
        .clock(clock),
        .reset(reset),
        .rhs_start(rhs_start),
        .rhs_data(rhs_data),
        .release_bank(release_bank),
        .rhs_ready(rhs_ready),
        .active_ready(active_ready),
        .rhs_cols(rhs_cols)
    );

    for (genvar c = 0; c < N; c++) begin : g_pe
        column_pe column_pe_inst (
            .clock(clock),
            .reset(reset),
            .lhs_col(lhs_col),
            .lhs_data(lhs_data),
            .rhs_col(rhs_cols[c]),
            .split(split),
            .out_idx(out_idx),
            .out_valid(out_valid),
            .col_out(pe_out[c]),
            .col_valid(pe_valid[c])
        );
    end

    // every PE sees the same schedule, so one set of flags is enough
    out_buffer out_buffer_inst (
        .clock(clock),
        .reset(reset),
        .collect_start(collect_start),
        .col_out(pe_out),
        .col_valid(pe_valid[0]),
        .out_start(out_start),
        .out_ready(out_ready),
        .out_data(out_data)
    );

endmodule

/* source/out_buffer.sv */
`timescale 1ns/10ps
`include "spmm_params.svh"

module out_buffer (
    input  logic            clock,
    input  logic            reset,
    input  logic            collect_start,
    input  spmm_pkg::data_t col_out [`SPMM_N][`SPMM_N],
    input  logic            col_valid [`SPMM_N],
    input  logic            out_start,
    output logic            out_ready,
    output spmm_pkg::data_t out_data [`SPMM_BEAT_ROWS][`SPMM_N]
);
    import spmm_pkg::*;

    localparam int N = `SPMM_N;
    localparam int ROWS = `SPMM_BEAT_ROWS;
    localparam int BEATS = `SPMM_BEATS;

    logic        col_en;
    lane_t       col_beat;
    logic        send_en;
    lane_t       send_beat;
    logic        hold_done;
    logic        send_done;
    logic        move;
    bank_state_t hold_state;
    bank_state_t send_state;
    data_t       hold_bank [N][N];
    data_t       send_bank [N][N];

    burst_counter #(
        .LENGTH(N)
    ) collect_counter_inst (
        .clock(clock),
        .reset(reset),
        .start(collect_start),
        .en(col_en),
        .count(col_beat)
    );

    burst_counter #(
        .LENGTH(BEATS)
    ) send_counter_inst (
        .clock(clock),
        .reset(reset),
        .start(out_start),
        .en(send_en),
        .count(send_beat)
    );

    assign hold_done = col_en && (col_beat == lane_t'(N - 1));
    assign send_done = send_en && (send_beat == lane_t'(BEATS - 1));
    assign move = (hold_state == bank_ready) && (send_state == bank_empty);

    always_ff @(posedge clock) begin
        if (reset) begin
            hold_state <= bank_empty;
            send_state <= bank_empty;
            out_ready <= 1'b0;
        end else begin
            case (hold_state)
                bank_empty: if (collect_start) hold_state <= bank_busy;
                bank_busy: if (hold_done) hold_state <= bank_ready;
                bank_ready: if (move) hold_state <= bank_empty;
                default: hold_state <= bank_empty;
            endcase
            case (send_state)
                bank_empty: if (move) send_state <= bank_ready;
                bank_ready: if (out_start) send_state <= send_done ? bank_empty : bank_sending;
                bank_sending: if (send_done) send_state <= bank_empty;
                default: send_state <= bank_empty;
            endcase
            out_ready <= (send_state == bank_ready) && !out_start;
        end
    end

    // rows still unwritten after the first beat are cleared for empty rows
    always_ff @(posedge clock) begin
        if (col_en) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    if (col_valid[r]) begin
                        hold_bank[r][c] <= col_out[c][r];
                    end else if (col_beat == '0) begin
                        hold_bank[r][c] <= '0;
                    end
                end
            end
        end
        if (move) begin
            send_bank <= hold_bank;
        end
    end

    always_comb begin
        for (int i = 0; i < ROWS; i++) begin
            for (int j = 0; j < N; j++) begin
                out_data[i][j] = send_en ? send_bank[int'(send_beat) * ROWS + i][j] : '0;
            end
        end
    end

endmodule

/* source/rhs_buffer.sv */
`timescale 1ns/10ps
`include "spmm_params.svh"

module rhs_buffer (
    input  logic            clock,
    input  logic            reset,
    input  logic            rhs_start,
    input  spmm_pkg::data_t rhs_data [`SPMM_BEAT_ROWS][`SPMM_N],
    input  logic            release_bank,
    output logic            rhs_ready,
    output logic            active_ready,
    output spmm_pkg::data_t rhs_cols [`SPMM_N][`SPMM_N]
);
    import spmm_pkg::*;

    localparam int N = `SPMM_N;
    localparam int ROWS = `SPMM_BEAT_ROWS;
    localparam int BEATS = `SPMM_BEATS;

    logic        wr_en;
    lane_t       wr_beat;
    logic        fill_done;
    logic        copy;
    bank_state_t fill_state;
    bank_state_t act_state;
    data_t       fill_bank [N][N];
    data_t       act_bank [N][N];

    burst_counter #(
        .LENGTH(BEATS)
    ) beat_counter_inst (
        .clock(clock),
        .reset(reset),
        .start(rhs_start),
        .en(wr_en),
        .count(wr_beat)
    );

    assign fill_done = wr_en && (wr_beat == lane_t'(BEATS - 1));
    assign copy = (fill_state == bank_ready) && (act_state == bank_empty);
    assign active_ready = (act_state == bank_ready);

    always_ff @(posedge clock) begin
        if (reset) begin
            fill_state <= bank_empty;
            act_state <= bank_empty;
            rhs_ready <= 1'b0;
        end else begin
            case (fill_state)
                bank_empty: if (rhs_start) fill_state <= fill_done ? bank_ready : bank_busy;
                bank_busy: if (fill_done) fill_state <= bank_ready;
                bank_ready: if (copy) fill_state <= bank_empty;
                default: fill_state <= bank_empty;
            endcase
            case (act_state)
                bank_empty: if (copy) act_state <= bank_ready;
                bank_ready: if (release_bank) act_state <= bank_empty;
                default: act_state <= bank_empty;
            endcase
            rhs_ready <= (fill_state == bank_empty) && !rhs_start;
        end
    end

    // stored transposed, so each PE reads one B column
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int i = 0; i < ROWS; i++) begin
                for (int j = 0; j < N; j++) begin
                    fill_bank[j][int'(wr_beat) * ROWS + i] <= rhs_data[i][j];
                end
            end
        end
        if (copy) begin
            act_bank <= fill_bank;
        end
    end

    assign rhs_cols = act_bank;

    assert property (@(posedge clock) disable iff (reset) rhs_start |-> rhs_ready);

endmodule

/* source/column_pe.sv */
`timescale 1ns/10ps
`include "spmm_params.svh"

module column_pe (
    input  logic            clock,
    input  logic            reset,
    input  spmm_pkg::lane_t lhs_col [`SPMM_N],
    input  spmm_pkg::data_t lhs_data [`SPMM_N],
    input  spmm_pkg::data_t rhs_col [`SPMM_N],
    input  logic            split [`SPMM_N],
    input  spmm_pkg::lane_t out_idx [`SPMM_N],
    input  logic            out_valid [`SPMM_N],
    output spmm_pkg::data_t col_out [`SPMM_N],
    output logic            col_valid [`SPMM_N]
);
    import spmm_pkg::*;

    localparam int N = `SPMM_N;
    localparam int LAT = `SPMM_PE_LAT;

    data_t prod [N];
    logic  split_d [N];
    lane_t idx_d [N];
    data_t red_out [N];
    data_t halo;
    logic  valid_pipe [LAT][N];
    logic  found;

    // product of each lane with the B entry of its column
    always_ff @(posedge clock) begin
        for (int j = 0; j < N; j++) begin
            prod[j] <= lhs_data[j] * rhs_col[lhs_col[j]];
        end
        idx_d <= out_idx;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            split_d <= '{default: 1'b0};
        end else begin
            split_d <= split;
        end
    end

    segment_reducer segment_reducer_inst (
        .clock(clock),
        .reset(reset),
        .data(prod),
        .split(split_d),
        .out_idx(idx_d),
        .out_data(red_out),
        .halo(halo)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_pipe <= '{default: 1'b0};
        end else begin
            valid_pipe[0] <= out_valid;
            for (int s = 1; s < LAT; s++) begin
                valid_pipe[s] <= valid_pipe[s-1];
            end
        end
    end

    assign col_valid = valid_pipe[LAT-1];

    // lowest finished row of the beat picks up the carried tail
    always_comb begin
        found = 1'b0;
        for (int j = 0; j < N; j++) begin
            col_out[j] = col_valid[j] ? red_out[j] : '0;
            if (col_valid[j] && !found) begin
                col_out[j] = red_out[j] + halo;
                found = 1'b1;
            end
        end
    end

    // each finished row points at a lane that closes a segment
    for (genvar j = 0; j < N; j++) begin : g_check
        assert property (@(posedge clock) disable iff (reset)
            out_valid[j] |-> split[out_idx[j]]);
    end

endmodule

/* source/segment_reducer.sv */
`timescale 1ns/10ps
`include "spmm_params.svh"

module segment_reducer (
    input  logic            clock,
    input  logic            reset,
    input  spmm_pkg::data_t data [`SPMM_N],
    input  logic            split [`SPMM_N],
    input  spmm_pkg::lane_t out_idx [`SPMM_N],
    output spmm_pkg::data_t out_data [`SPMM_N],
    output spmm_pkg::data_t halo
);
    import spmm_pkg::*;

    localparam int N = `SPMM_N;
    localparam int LG = `SPMM_LG_N;

    data_t scan [LG+1][N];
    logic  split_pipe [LG][N];
    lane_t idx_pipe [LG+1][N];
    data_t seg [N];
    data_t part_sum [N];
    data_t base;
    logic  any_split;
    data_t tail;
    data_t tail_d;

    // Hillis-Steele scan, one register per level
    for (genvar j = 0; j < N; j++) begin : g_leaf
        assign scan[0][j] = data[j];
    end

    for (genvar l = 0; l < LG; l++) begin : g_level
        for (genvar j = 0; j < N; j++) begin : g_lane
            if (j >= (1 << l)) begin : g_add
                always_ff @(posedge clock) begin
                    scan[l+1][j] <= scan[l][j] + scan[l][j - (1 << l)];
                end
            end else begin : g_pass
                always_ff @(posedge clock) begin
                    scan[l+1][j] <= scan[l][j];
                end
            end
        end
    end

    // flags follow the scan, indices one stage further
    always_ff @(posedge clock) begin
        if (reset) begin
            split_pipe <= '{default: 1'b0};
        end else begin
            split_pipe[0] <= split;
            for (int s = 1; s < LG; s++) begin
                split_pipe[s] <= split_pipe[s-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        idx_pipe[0] <= out_idx;
        for (int s = 1; s <= LG; s++) begin
            idx_pipe[s] <= idx_pipe[s-1];
        end
    end

    // segment sum is the prefix minus the prefix at the previous split
    always_comb begin
        base = '0;
        any_split = 1'b0;
        for (int j = 0; j < N; j++) begin
            seg[j] = scan[LG][j] - base;
            if (split_pipe[LG-1][j]) begin
                base = scan[LG][j];
                any_split = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        part_sum <= seg;
        for (int j = 0; j < N; j++) begin
            out_data[j] <= part_sum[idx_pipe[LG][j]];
        end
    end

    // a beat without any split adds itself to the running tail
    // halo trails the tail by two stages to meet the routed beat
    always_ff @(posedge clock) begin
        if (reset) begin
            tail <= '0;
            tail_d <= '0;
            halo <= '0;
        end else begin
            tail <= scan[LG][N-1] - base + (any_split ? '0 : tail);
            tail_d <= tail;
            halo <= tail_d;
        end
    end

endmodule

/* source/row_scheduler.sv */
`timescale 1ns/10ps
`include "spmm_params.svh"

module row_scheduler (
    input  logic            clock,
    input  logic            reset,
    input  logic            lhs_start,
    input  spmm_pkg::flat_t row_end [`SPMM_N],
    output logic            split [`SPMM_N],
    output spmm_pkg::lane_t out_idx [`SPMM_N],
    output logic            out_valid [`SPMM_N]
);
    import spmm_pkg::*;

    localparam int N = `SPMM_N;
    localparam int LG = `SPMM_LG_N;

    logic  en;
    lane_t beat;
    logic  split_table [N][N];
    lane_t empty_after [N];
    lane_t done_rows;
    lane_t next_row;

    burst_counter #(
        .LENGTH(N)
    ) beat_counter_inst (
        .clock(clock),
        .reset(reset),
        .start(lhs_start),
        .en(en),
        .count(beat)
    );

    // one bit per row end, by beat and lane
    // empty rows repeat an end and land on the same bit
    always_comb begin
        for (int b = 0; b < N; b++) begin
            for (int l = 0; l < N; l++) begin
                split_table[b][l] = 1'b0;
            end
        end
        for (int r = 0; r < N; r++) begin
            split_table[row_end[r][2*LG-1:LG]][row_end[r][LG-1:0]] = 1'b1;
        end
    end

    // run of empty rows directly behind each row
    always_comb begin
        empty_after[N-1] = '0;
        for (int r = N - 2; r >= 0; r--) begin
            if (row_end[r+1] == row_end[r]) begin
                empty_after[r] = empty_after[r+1] + 1'b1;
            end else begin
                empty_after[r] = '0;
            end
        end
    end

    // idle beats close at the last lane, so no tail is carried into a burst
    always_comb begin
        for (int l = 0; l < N; l++) begin
            split[l] = en ? split_table[beat][l] : (l == N - 1);
        end
    end

    // each split finishes the next row; empty rows are skipped
    always_comb begin
        next_row = done_rows;
        for (int l = 0; l < N; l++) begin
            out_idx[l] = '0;
            out_valid[l] = 1'b0;
        end
        for (int l = 0; l < N; l++) begin
            if (en && split[l]) begin
                out_idx[next_row] = lane_t'(l);
                out_valid[next_row] = 1'b1;
                next_row = next_row + empty_after[next_row] + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || !en) begin
            done_rows <= '0;
        end else begin
            done_rows <= next_row;
        end
    end

endmodule

/* source/burst_counter.sv */
`timescale 1ns/10ps
`include "spmm_params.svh"

module burst_counter #(
    parameter int LENGTH = `SPMM_N
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            start,
    output logic            en,
    output spmm_pkg::lane_t count
);
    import spmm_pkg::*;

    logic  started;
    lane_t ctr;

    // window opens in the start cycle itself
    assign en = start || started;
    assign count = ctr;

    always_ff @(posedge clock) begin
        if (reset) begin
            started <= 1'b0;
            ctr <= '0;
        end else if (en) begin
            if (ctr == lane_t'(LENGTH - 1)) begin
                started <= 1'b0;
                ctr <= '0;
            end else begin
                started <= 1'b1;
                ctr <= ctr + 1'b1;
            end
        end
    end

    // next burst only once the running one has wrapped
    assert property (@(posedge clock) disable iff (reset) start |-> !started);

endmodule

/* source/spmm_pkg.sv */
`include "spmm_params.svh"

package spmm_pkg;

    typedef logic [`SPMM_W-1:0] data_t;
    typedef logic [`SPMM_LG_N-1:0] lane_t;
    // beat index in the upper half, lane in the lower half
    typedef logic [2*`SPMM_LG_N-1:0] flat_t;

    typedef enum logic [1:0] {
        bank_empty,
        bank_busy,
        bank_ready,
        bank_sending
    } bank_state_t;

endpackage

/* include/spmm_params.svh */
`ifndef SPMM_PARAMS_SVH
`define SPMM_PARAMS_SVH

// matrix size, a power of two and at least 4
`define SPMM_N 8
// element width in bits
`define SPMM_W 8
// rows carried by one B or C beat
`define SPMM_BEAT_ROWS 4

`define SPMM_LG_N ($clog2(`SPMM_N))
`define SPMM_BEATS (`SPMM_N / `SPMM_BEAT_ROWS)

// registered multiply ahead of the reducer
`define SPMM_MUL_LAT 1
// multiply, log2 N scan levels, segment stage and routing stage
`define SPMM_PE_LAT (`SPMM_LG_N + 2 + `SPMM_MUL_LAT)

`endif
